// File: src/conflict_pkg.sv
`default_nettype none

package conflict_pkg;

    // Widths of the transaction fields and the statistics counters
    localparam int DEP_WIDTH   = 64;
    localparam int OWNER_WIDTH = 64;
    localparam int COUNT_WIDTH = 32;

    typedef logic [OWNER_WIDTH-1:0] owner_id_t;
    typedef logic [DEP_WIDTH-1:0]   dep_vec_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // One transaction as it enters the checker
    typedef struct packed {
        owner_id_t owner;
        dep_vec_t  read_deps;
        dep_vec_t  write_deps;
    } txn_t;

    // Checked transaction with its conflict flags
    typedef struct packed {
        txn_t txn;
        logic raw;
        logic waw;
        logic war;
        logic has_conflict;
    } result_t;

    // Counters kept across batches, cleared only by reset
    typedef struct packed {
        count_t raw_count;
        count_t waw_count;
        count_t war_count;
        count_t filter_hits;
    } stats_t;

endpackage

`default_nettype wire

// File: src/txn_ingress.sv
`timescale 1ns/1ns
`default_nettype none

module txn_ingress
    import conflict_pkg::*;
#(
    parameter int IN_DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic in_valid,
    input  wire txn_t in_txn,
    input  wire logic pop,
    output logic      in_credit,
    output txn_t      head,
    output logic      not_empty
);

    localparam int PW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CW = $clog2(IN_DEPTH + 1);

    txn_t           mem [IN_DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           full;
    logic           push;
    logic           do_pop;

    // Pointer wrap that also works for depths that are not a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        logic [PW-1:0] nxt;
        if (ptr == PW'(IN_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full      = (count == CW'(IN_DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    // Upstream only sends under credit, so a full FIFO never sees a push
    assign push   = in_valid && !full;
    assign do_pop = pop && not_empty;

    // Storage array
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_txn;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit goes back upstream for every entry that leaves
            in_credit <= do_pop;
        end
    end

endmodule

`default_nettype wire

// File: src/dependency_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dependency_checker
    import conflict_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire txn_t head,
    input  wire logic not_empty,
    input  wire logic credit_avail,
    input  wire logic batch_completed,
    output logic      pop,
    output logic      res_valid,
    output result_t   res,
    output stats_t    stats
);

    // Read and write sets gathered from committed transactions of this batch
    dep_vec_t read_set;
    dep_vec_t write_set;

    logic raw_hit;
    logic waw_hit;
    logic war_hit;
    logic any_hit;

    // A check needs both an entry and a free downstream credit
    assign pop = not_empty && credit_avail;

    // Reads against batch writes
    assign raw_hit = |(head.read_deps & write_set);
    // Writes against batch writes
    assign waw_hit = |(head.write_deps & write_set);
    // Writes against batch reads
    assign war_hit = |(head.write_deps & read_set);

    assign any_hit = raw_hit || waw_hit || war_hit;

    // Result payload
    always_ff @(posedge clk) begin
        if (pop) begin
            res.txn          <= head;
            res.raw          <= raw_hit;
            res.waw          <= waw_hit;
            res.war          <= war_hit;
            res.has_conflict <= any_hit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= pop;
        end
    end

    // Batch sets
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_set  <= '0;
            write_set <= '0;
        end else if (batch_completed) begin
            // Clear wins over a commit in the same cycle
            read_set  <= '0;
            write_set <= '0;
        end else if (pop && !any_hit) begin
            read_set  <= read_set | head.read_deps;
            write_set <= write_set | head.write_deps;
        end
    end

    // Statistics survive batch boundaries
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stats <= '0;
        end else if (pop) begin
            if (raw_hit) begin
                stats.raw_count <= stats.raw_count + count_t'(1);
            end
            if (waw_hit) begin
                stats.waw_count <= stats.waw_count + count_t'(1);
            end
            if (war_hit) begin
                stats.war_count <= stats.war_count + count_t'(1);
            end
            // Counted once per transaction, whatever the number of kinds
            if (any_hit) begin
                stats.filter_hits <= stats.filter_hits + count_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/txn_egress.sv
`timescale 1ns/1ns
`default_nettype none

module txn_egress
    import conflict_pkg::*;
#(
    parameter int OUT_CREDITS = 2
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    res_valid,
    input  wire result_t res,
    input  wire logic    out_credit,
    output logic         credit_avail,
    output logic         out_valid,
    output result_t      out_result
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] credit_cnt;

    // A result still sitting in the checker stage already owns one credit
    assign credit_avail = (credit_cnt > CW'(res_valid));

    // Downstream credit counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CW'(OUT_CREDITS);
        end else begin
            case ({res_valid, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (res_valid) begin
            out_result <= res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= res_valid;
        end
    end

endmodule

`default_nettype wire

// File: src/conflict_checker_top.sv
`timescale 1ns/1ns
`default_nettype none

module conflict_checker_top
    import conflict_pkg::*;
#(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic in_valid,
    input  wire txn_t in_txn,
    input  wire logic out_credit,
    input  wire logic batch_completed,
    output logic      in_credit,
    output logic      out_valid,
    output result_t   out_result,
    output stats_t    stats
);

    // Ingress to checker
    txn_t    head;
    logic    not_empty;
    logic    pop;

    // Checker to egress
    logic    credit_avail;
    logic    res_valid;
    result_t res;

    txn_ingress #(
        .IN_DEPTH (IN_DEPTH)
    ) ingress_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_txn    (in_txn),
        .pop       (pop),
        .in_credit (in_credit),
        .head      (head),
        .not_empty (not_empty)
    );

    dependency_checker checker_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .head            (head),
        .not_empty       (not_empty),
        .credit_avail    (credit_avail),
        .batch_completed (batch_completed),
        .pop             (pop),
        .res_valid       (res_valid),
        .res             (res),
        .stats           (stats)
    );

    txn_egress #(
        .OUT_CREDITS (OUT_CREDITS)
    ) egress_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_valid    (res_valid),
        .res          (res),
        .out_credit   (out_credit),
        .credit_avail (credit_avail),
        .out_valid    (out_valid),
        .out_result   (out_result)
    );

endmodule

`default_nettype wire

// File: tb/conflict_checker_properties.sv
`timescale 1ns/1ns
`default_nettype none

module conflict_checker_properties #(
    parameter int OUT_CREDITS = 2
) (
    input wire logic                               clk,
    input wire logic                               rst_n,
    input wire logic                               in_valid,
    input wire logic                               fifo_full,
    input wire logic                               out_valid,
    input wire logic [$clog2(OUT_CREDITS + 1)-1:0] credit_cnt
);

    // Upstream credit keeps pushes away from a full FIFO
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) in_valid |-> !fifo_full
    ) else $error("ingress push while the FIFO is full");

    credit_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) credit_cnt <= OUT_CREDITS
    ) else $error("egress credit count above its starting value");

    // The credit for an output is taken in the cycle before it appears
    out_has_credit: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> $past(credit_cnt) != '0
    ) else $error("output sent without a downstream credit");

endmodule

bind conflict_checker_top conflict_checker_properties #(
    .OUT_CREDITS (OUT_CREDITS)
) properties_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .fifo_full  (ingress_i.full),
    .out_valid  (out_valid),
    .credit_cnt (egress_i.credit_cnt)
);

`default_nettype wire

// File: tb/conflict_checker_tb.sv
`timescale 1ns/1ns
`default_nettype none

module conflict_checker_tb
    import conflict_pkg::*;
();

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int DRV_DLY     = 2;
    localparam int RAND_TXNS   = 200;
    localparam int RAND_BATCH  = 50;

    logic    clk = 1'b0;
    logic    rst_n = 1'b0;
    logic    in_valid;
    txn_t    in_txn;
    logic    out_credit;
    logic    batch_completed;
    logic    in_credit;
    logic    out_valid;
    result_t out_result;
    stats_t  stats;

    // Reference batch sets, counters and expected results in send order
    dep_vec_t ref_read = '0;
    dep_vec_t ref_write = '0;
    stats_t   ref_stats = '0;
    result_t  exp_q[$];
    result_t  last_result;

    longint due_q[$];
    longint cycle_count = 0;
    int     up_credits = IN_DEPTH;
    int     sent_count = 0;
    int     recv_count = 0;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    conflict_checker_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) conflict_checker_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_txn          (in_txn),
        .out_credit      (out_credit),
        .batch_completed (batch_completed),
        .in_credit       (in_credit),
        .out_valid       (out_valid),
        .out_result      (out_result),
        .stats           (stats)
    );

    always #20 clk = ~clk;

    function automatic dep_vec_t one_hot(input int n);
        return dep_vec_t'(1) << n;
    endfunction

    function automatic txn_t make_txn(input owner_id_t owner, input dep_vec_t rd,
                                      input dep_vec_t wr);
        txn_t t;
        t.owner      = owner;
        t.read_deps  = rd;
        t.write_deps = wr;
        return t;
    endfunction

    // Zero to two random bits
    function automatic dep_vec_t sparse_vec();
        dep_vec_t v;
        int       n;
        v = '0;
        n = $urandom_range(0, 2);
        for (int k = 0; k < n; k++) begin
            v[$urandom_range(0, DEP_WIDTH - 1)] = 1'b1;
        end
        return v;
    endfunction

    // Expected result by the conflict rules, committing only clean transactions
    function automatic result_t predict(input txn_t t);
        result_t r;
        r.txn          = t;
        r.raw          = (t.read_deps & ref_write) != '0;
        r.waw          = (t.write_deps & ref_write) != '0;
        r.war          = (t.write_deps & ref_read) != '0;
        r.has_conflict = r.raw || r.waw || r.war;
        if (r.raw) begin
            ref_stats.raw_count = ref_stats.raw_count + 1;
        end
        if (r.waw) begin
            ref_stats.waw_count = ref_stats.waw_count + 1;
        end
        if (r.war) begin
            ref_stats.war_count = ref_stats.war_count + 1;
        end
        if (r.has_conflict) begin
            ref_stats.filter_hits = ref_stats.filter_hits + 1;
        end else begin
            ref_read  = ref_read | t.read_deps;
            ref_write = ref_write | t.write_deps;
        end
        return r;
    endfunction

    task automatic check_word(input string name, input logic [63:0] exp,
                              input logic [63:0] got);
        if (got !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_stats(input stats_t exp);
        check_word("stats.raw_count", 64'(exp.raw_count), 64'(stats.raw_count));
        check_word("stats.waw_count", 64'(exp.waw_count), 64'(stats.waw_count));
        check_word("stats.war_count", 64'(exp.war_count), 64'(stats.war_count));
        check_word("stats.filter_hits", 64'(exp.filter_hits),
                   64'(stats.filter_hits));
    endtask

    task automatic expect_flags(input logic raw, input logic waw, input logic war);
        check_flag("out_result.raw", raw, last_result.raw);
        check_flag("out_result.waw", waw, last_result.waw);
        check_flag("out_result.war", war, last_result.war);
        check_flag("out_result.has_conflict", raw | waw | war, last_result.has_conflict);
    endtask

    // Called and returns a small delay after a rising edge
    task automatic send_txn(input txn_t t);
        result_t exp;
        while (up_credits == 0) begin
            @(posedge clk);
            #DRV_DLY;
        end
        exp = predict(t);
        exp_q.push_back(exp);
        in_valid = 1'b1;
        in_txn   = t;
        up_credits--;
        sent_count++;
        @(posedge clk);
        #DRV_DLY;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #DRV_DLY;
        end
    endtask

    task automatic clear_batch();
        batch_completed = 1'b1;
        ref_read  = '0;
        ref_write = '0;
        @(posedge clk);
        #DRV_DLY;
        batch_completed = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
        end
    endtask

    // Upstream credit returned by the ingress
    always @(negedge clk) begin : upstream_credit
        if (rst_n && in_credit) begin
            up_credits++;
            if (up_credits > IN_DEPTH) begin
                $display("ERROR: ingress returned more credits than it was given");
                errors++;
            end
        end
    end

    always @(negedge clk) begin : compare
        result_t exp;
        if (rst_n && out_valid) begin
            recv_count++;
            last_result = out_result;
            due_q.push_back(cycle_count + 1 + $urandom_range(0, 5));
            if (exp_q.size() == 0) begin
                $display("ERROR: output for owner 0x%h arrived with nothing outstanding",
                         out_result.txn.owner);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                check_word("out_result.txn.owner", exp.txn.owner, out_result.txn.owner);
                check_word("out_result.txn.read_deps", exp.txn.read_deps,
                           out_result.txn.read_deps);
                check_word("out_result.txn.write_deps", exp.txn.write_deps,
                           out_result.txn.write_deps);
                check_flag("out_result.raw", exp.raw, out_result.raw);
                check_flag("out_result.waw", exp.waw, out_result.waw);
                check_flag("out_result.war", exp.war, out_result.war);
                check_flag("out_result.has_conflict", exp.has_conflict,
                           out_result.has_conflict);
            end
        end
    end

    // Downstream returns one credit per cycle once its delay has passed
    always @(posedge clk) begin : credit_return
        int idx;
        cycle_count++;
        #DRV_DLY;
        idx = -1;
        for (int k = 0; k < due_q.size(); k++) begin
            if (idx < 0 && due_q[k] <= cycle_count) begin
                idx = k;
            end
        end
        if (idx >= 0) begin
            out_credit = 1'b1;
            due_q.delete(idx);
        end else begin
            out_credit = 1'b0;
        end
    end

    always @(negedge clk) begin : watchdog
        if (cycle_count > 300 * longint'(sent_count) + 1000) begin
            $display("ERROR: run stopped by watchdog after %0d cycles, %0d sent, %0d received",
                     cycle_count, sent_count, recv_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : main
        int     err_start;
        stats_t snap;
        void'($urandom(32'h6d71_f312));
        in_valid        = 1'b0;
        in_txn          = '0;
        out_credit      = 1'b0;
        batch_completed = 1'b0;
        repeat (3) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        err_start = errors;
        repeat (5) begin
            @(negedge clk);
            check_flag("in_credit", 1'b0, in_credit);
            check_flag("out_valid", 1'b0, out_valid);
        end
        check_stats('0);
        @(posedge clk);
        #DRV_DLY;
        finish_test("idle after reset", err_start);

        err_start = errors;
        snap = stats;
        for (int i = 0; i < 8; i++) begin
            send_txn(make_txn(64'ha000_0000_0000_0000 | 64'(i),
                              dep_vec_t'(3) << (4 * i), dep_vec_t'(4) << (4 * i)));
        end
        wait_drain();
        check_word("stats.filter_hits", 64'(snap.filter_hits), 64'(stats.filter_hits));
        check_stats(ref_stats);
        clear_batch();
        finish_test("disjoint stream", err_start);

        // Base commits read bit 0 and write bit 1, then one conflict kind each
        err_start = errors;
        snap = stats;
        send_txn(make_txn(64'hb000_0000_0000_0000, one_hot(0), one_hot(1)));
        send_txn(make_txn(64'hb000_0000_0000_0001, one_hot(1), one_hot(10)));
        wait_drain();
        expect_flags(1'b1, 1'b0, 1'b0);
        send_txn(make_txn(64'hb000_0000_0000_0002, one_hot(11), one_hot(1)));
        wait_drain();
        expect_flags(1'b0, 1'b1, 1'b0);
        send_txn(make_txn(64'hb000_0000_0000_0003, one_hot(12), one_hot(0)));
        wait_drain();
        expect_flags(1'b0, 1'b0, 1'b1);
        check_word("stats.raw_count", 64'(snap.raw_count + 1), 64'(stats.raw_count));
        check_word("stats.waw_count", 64'(snap.waw_count + 1), 64'(stats.waw_count));
        check_word("stats.war_count", 64'(snap.war_count + 1), 64'(stats.war_count));
        check_word("stats.filter_hits", 64'(snap.filter_hits + 3), 64'(stats.filter_hits));
        check_stats(ref_stats);
        finish_test("single conflict kinds", err_start);

        // Bits 10, 11 and 12 belong only to the rejected transactions
        err_start = errors;
        send_txn(make_txn(64'hc000_0000_0000_0000, one_hot(10),
                          one_hot(11) | one_hot(12)));
        wait_drain();
        expect_flags(1'b0, 1'b0, 1'b0);
        check_stats(ref_stats);
        finish_test("no commit on conflict", err_start);

        err_start = errors;
        snap = stats;
        clear_batch();
        send_txn(make_txn(64'hd000_0000_0000_0000, one_hot(1), one_hot(0)));
        wait_drain();
        expect_flags(1'b0, 1'b0, 1'b0);
        check_stats(snap);
        check_stats(ref_stats);
        finish_test("batch clear", err_start);

        err_start = errors;
        for (int i = 0; i < RAND_TXNS; i++) begin
            send_txn(make_txn({$urandom(), $urandom()}, sparse_vec(), sparse_vec()));
            if ($urandom_range(0, 3) == 0) begin
                @(posedge clk);
                #DRV_DLY;
            end
            if ((i % RAND_BATCH) == RAND_BATCH - 1) begin
                wait_drain();
                clear_batch();
            end
        end
        wait_drain();
        repeat (10) @(negedge clk);
        check_stats(ref_stats);
        check_word("recv_count", 64'(sent_count), 64'(recv_count));
        finish_test("random stream", err_start);

        $display("summary: %0d tests, %0d failed, %0d check errors, %0d sent, %0d received",
                 tests_run, tests_failed, errors, sent_count, recv_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/conflict_pkg.sv
src/txn_ingress.sv
src/dependency_checker.sv
src/txn_egress.sv
src/conflict_checker_top.sv
tb/conflict_checker_properties.sv
tb/conflict_checker_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the conflict checker simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module conflict_checker_tb \
    -f sim.f \
    -o conflict_checker_sim

./obj_dir/conflict_checker_sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
